//--- phone_ui_pkg.sv
`default_nettype none

package phone_ui_pkg;

	//////////////////////////////
	// call states
	//////////////////////////////
	typedef enum logic [2:0] {
		idle       = 3'd0, // no call
		incoming   = 3'd1, // node is being called
		outgoing   = 3'd2, // node is calling
		busy       = 3'd3, // call in progress
		initialize = 3'd5  // waiting for first enter
	} call_state_t;

	//////////////////////////////
	// menu items
	//////////////////////////////
	typedef enum logic [5:0] {
		call_number  = 6'd0,  // main menu
		volume       = 6'd1,
		get_num      = 6'd3,
		set_time     = 6'd4,
		dialing      = 6'd7,  // switches being set
		change_vol   = 6'd8,  // pending volume steps
		disp_num     = 6'd30, // empty leaf
		set_dt       = 6'd31, // empty leaf
		def_incoming = 6'd32, // incoming menu
		accept       = 6'd33,
		reject       = 6'd34,
		def_outgoing = 6'd36, // outgoing menu
		end_call     = 6'd37,
		def_busy     = 6'd38, // in-call menu
		end_call_b   = 6'd39,
		set_volume   = 6'd40,
		def_welcome  = 6'd50, // idle entry screen
		def_init     = 6'd51, // power-up screen
		def_sys      = 6'd53  // idle top level
	} menu_item_t;

	// ui -> application layer
	typedef enum logic [2:0] {
		ui_none   = 3'd0,
		make_call = 3'd1,
		stop_call = 3'd2
	} ui_cmd_t;

	// application layer -> ui
	typedef enum logic [2:0] {
		app_none      = 3'd0,
		connected     = 3'd1, // far end picked up
		failed        = 3'd4, // dropped or never went through
		incoming_call = 3'd5,
		call_ended    = 3'd6
	} app_cmd_t;

	//////////////////////////////
	// buses
	//////////////////////////////
	typedef struct packed {
		logic enter;
		logic up;
		logic down;
		logic left;
		logic right;
	} buttons_t;

	// one-cycle strobes, at most one set
	typedef struct packed {
		logic step_up;
		logic step_down;
		logic commit;
		logic cancel;
	} vol_ctrl_t;

	typedef logic [4:0] volume_t;
	localparam volume_t VOLUME_MAX = '1; // 31, top of the range

	typedef logic [10:0] text_addr_t; // address or length into text memory

	typedef struct packed {
		logic       start;  // one-cycle kick for the scroller
		text_addr_t addr;
		text_addr_t length;
	} text_req_t;

	typedef logic [7:0] phone_num_t; // node address on the network

endpackage

`default_nettype wire

//--- call_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module call_fsm (
	input wire clk,
	input wire reset,
	input wire phone_ui_pkg::buttons_t buttons,
	input wire phone_ui_pkg::phone_num_t dial_switches,
	input wire phone_ui_pkg::app_cmd_t app_command,
	output phone_ui_pkg::call_state_t call_state,
	output phone_ui_pkg::menu_item_t menu_item,
	output phone_ui_pkg::ui_cmd_t ui_command,
	output phone_ui_pkg::phone_num_t dial_address,
	output phone_ui_pkg::vol_ctrl_t vol_ctrl
);

	phone_ui_pkg::buttons_t   btn_q; // sampled buttons
	phone_ui_pkg::app_cmd_t   app_q; // sampled app report
	phone_ui_pkg::phone_num_t sw_q;  // sampled switches

	//////////////////////////////
	// input sampling
	//////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			btn_q <= '0;
			app_q <= phone_ui_pkg::app_none;
		end else begin
			btn_q <= buttons;
			app_q <= app_command;
		end
	end

	always_ff @(posedge clk)
		sw_q <= dial_switches;

	//////////////////////////////
	// call state + menu
	//////////////////////////////
	always_ff @(posedge clk) begin
		vol_ctrl <= '0; // strobes, one cycle only
		if (reset) begin
			call_state <= phone_ui_pkg::initialize;
			menu_item  <= phone_ui_pkg::def_init;
			ui_command <= phone_ui_pkg::ui_none;
		end else begin
			case (call_state)
				phone_ui_pkg::initialize: begin
					if (btn_q.enter) begin
						call_state <= phone_ui_pkg::idle;
						menu_item  <= phone_ui_pkg::def_welcome;
						ui_command <= phone_ui_pkg::ui_none;
					end
				end

				phone_ui_pkg::idle: begin
					if (app_q == phone_ui_pkg::incoming_call) begin // wins over buttons
						call_state <= phone_ui_pkg::incoming;
						menu_item  <= phone_ui_pkg::def_incoming;
					end else if (btn_q.up) begin // previous item
						case (menu_item)
							phone_ui_pkg::call_number: menu_item <= phone_ui_pkg::set_time;
							phone_ui_pkg::volume: menu_item <= phone_ui_pkg::call_number;
							phone_ui_pkg::get_num: menu_item <= phone_ui_pkg::volume;
							phone_ui_pkg::set_time: menu_item <= phone_ui_pkg::get_num;
							phone_ui_pkg::change_vol: vol_ctrl.step_up <= 1'b1;
							default: ;
						endcase
					end else if (btn_q.down) begin // next item
						case (menu_item)
							phone_ui_pkg::call_number: menu_item <= phone_ui_pkg::volume;
							phone_ui_pkg::volume: menu_item <= phone_ui_pkg::get_num;
							phone_ui_pkg::get_num: menu_item <= phone_ui_pkg::set_time;
							phone_ui_pkg::set_time: menu_item <= phone_ui_pkg::call_number;
							phone_ui_pkg::change_vol: vol_ctrl.step_down <= 1'b1;
							default: ;
						endcase
					end else if (btn_q.enter || btn_q.right) begin // select
						case (menu_item)
							phone_ui_pkg::def_welcome,
							phone_ui_pkg::def_sys: menu_item <= phone_ui_pkg::call_number;
							phone_ui_pkg::volume: menu_item <= phone_ui_pkg::change_vol;
							phone_ui_pkg::get_num: menu_item <= phone_ui_pkg::disp_num;
							phone_ui_pkg::set_time: menu_item <= phone_ui_pkg::set_dt;
							phone_ui_pkg::call_number: menu_item <= phone_ui_pkg::dialing;
							phone_ui_pkg::change_vol: begin
								vol_ctrl.commit <= 1'b1; // keep new level
								menu_item       <= phone_ui_pkg::volume;
							end
							phone_ui_pkg::dialing: begin
								dial_address <= sw_q; // number from the switches
								ui_command   <= phone_ui_pkg::make_call;
								call_state   <= phone_ui_pkg::outgoing;
								menu_item    <= phone_ui_pkg::def_outgoing;
							end
							default: ;
						endcase
					end else if (btn_q.left) begin // one level up
						case (menu_item)
							phone_ui_pkg::call_number,
							phone_ui_pkg::volume,
							phone_ui_pkg::get_num,
							phone_ui_pkg::set_time: menu_item <= phone_ui_pkg::def_sys;
							phone_ui_pkg::dialing: menu_item <= phone_ui_pkg::call_number;
							phone_ui_pkg::change_vol: begin
								vol_ctrl.cancel <= 1'b1; // drop pending steps
								menu_item       <= phone_ui_pkg::volume;
							end
							phone_ui_pkg::disp_num: menu_item <= phone_ui_pkg::get_num;
							phone_ui_pkg::set_dt: menu_item <= phone_ui_pkg::set_time;
							default: ;
						endcase
					end
				end

				phone_ui_pkg::incoming: begin
					if (btn_q.up) begin
						case (menu_item)
							phone_ui_pkg::def_incoming: menu_item <= phone_ui_pkg::reject;
							phone_ui_pkg::accept: menu_item <= phone_ui_pkg::def_incoming;
							default: menu_item <= phone_ui_pkg::accept;
						endcase
					end else if (btn_q.down) begin
						case (menu_item)
							phone_ui_pkg::def_incoming: menu_item <= phone_ui_pkg::accept;
							phone_ui_pkg::accept: menu_item <= phone_ui_pkg::reject;
							default: menu_item <= phone_ui_pkg::def_incoming;
						endcase
					end else if (btn_q.enter) begin
						if (menu_item == phone_ui_pkg::reject) begin
							call_state <= phone_ui_pkg::idle;
							menu_item  <= phone_ui_pkg::def_sys;
							ui_command <= phone_ui_pkg::ui_none;
						end else begin // def_incoming answers too
							call_state <= phone_ui_pkg::busy;
							menu_item  <= phone_ui_pkg::def_busy;
						end
					end
				end

				phone_ui_pkg::outgoing: begin
					if (app_q == phone_ui_pkg::connected) begin
						call_state <= phone_ui_pkg::busy;
						menu_item  <= phone_ui_pkg::def_busy;
					end else if (app_q == phone_ui_pkg::failed ||
							app_q == phone_ui_pkg::call_ended) begin
						call_state <= phone_ui_pkg::idle;
						menu_item  <= phone_ui_pkg::def_sys;
						ui_command <= phone_ui_pkg::ui_none;
					end else if (btn_q.up || btn_q.down) begin // two items, toggle
						menu_item <= (menu_item == phone_ui_pkg::end_call) ?
							phone_ui_pkg::def_outgoing : phone_ui_pkg::end_call;
					end else if (btn_q.enter && menu_item == phone_ui_pkg::end_call) begin
						ui_command <= phone_ui_pkg::stop_call; // wait for call_ended
					end
				end

				phone_ui_pkg::busy: begin
					if (app_q == phone_ui_pkg::call_ended) begin
						call_state <= phone_ui_pkg::idle;
						menu_item  <= phone_ui_pkg::def_sys;
						ui_command <= phone_ui_pkg::ui_none;
					end else if (btn_q.up) begin
						case (menu_item)
							phone_ui_pkg::def_busy: menu_item <= phone_ui_pkg::set_volume;
							phone_ui_pkg::end_call_b: menu_item <= phone_ui_pkg::def_busy;
							phone_ui_pkg::set_volume: menu_item <= phone_ui_pkg::end_call_b;
							default: vol_ctrl.step_up <= 1'b1; // change_vol
						endcase
					end else if (btn_q.down) begin
						case (menu_item)
							phone_ui_pkg::def_busy: menu_item <= phone_ui_pkg::end_call_b;
							phone_ui_pkg::end_call_b: menu_item <= phone_ui_pkg::set_volume;
							phone_ui_pkg::set_volume: menu_item <= phone_ui_pkg::def_busy;
							default: vol_ctrl.step_down <= 1'b1;
						endcase
					end else if (btn_q.enter) begin
						case (menu_item)
							phone_ui_pkg::end_call_b: ui_command <= phone_ui_pkg::stop_call;
							phone_ui_pkg::set_volume: menu_item <= phone_ui_pkg::change_vol;
							phone_ui_pkg::change_vol: vol_ctrl.commit <= 1'b1; // stay
							default: ;
						endcase
					end else if (btn_q.left && menu_item == phone_ui_pkg::change_vol) begin
						vol_ctrl.cancel <= 1'b1;
						menu_item       <= phone_ui_pkg::set_volume;
					end
				end

				default: begin // unused code, back to power-up
					call_state <= phone_ui_pkg::initialize;
					menu_item  <= phone_ui_pkg::def_init;
				end
			endcase
		end
	end

	//////////////////////////////
	// checks
	//////////////////////////////
	a_state_legal: assert property (@(posedge clk) disable iff (reset)
		call_state inside {phone_ui_pkg::idle, phone_ui_pkg::incoming,
			phone_ui_pkg::outgoing, phone_ui_pkg::busy, phone_ui_pkg::initialize});

	a_step_excl: assert property (@(posedge clk) disable iff (reset)
		!(vol_ctrl.step_up && vol_ctrl.step_down));

endmodule

`default_nettype wire

//--- volume_counter.sv
`timescale 1ns/1ps
`default_nettype none

module volume_counter #(
	parameter phone_ui_pkg::volume_t DEFAULT_VOLUME = 5'd16
) (
	input wire clk,
	input wire reset,
	input wire phone_ui_pkg::vol_ctrl_t vol_ctrl,
	output phone_ui_pkg::volume_t headphone_volume
);

	phone_ui_pkg::volume_t pending;   // level while the user is still stepping
	phone_ui_pkg::volume_t committed; // level the headphones actually get

	always_ff @(posedge clk) begin
		if (reset) begin
			pending   <= DEFAULT_VOLUME;
			committed <= DEFAULT_VOLUME;
		end else begin
			if (vol_ctrl.step_up && pending != phone_ui_pkg::VOLUME_MAX)
				pending <= pending + 5'd1; // saturate at top
			else if (vol_ctrl.step_down && pending != '0)
				pending <= pending - 5'd1; // saturate at zero
			else if (vol_ctrl.cancel)
				pending <= committed; // throw away the steps

			if (vol_ctrl.commit)
				committed <= pending;
		end
	end

	assign headphone_volume = committed;

	//////////////////////////////
	// checks
	//////////////////////////////

	// fsm never asks for both in the same cycle
	a_commit_cancel_excl: assert property (@(posedge clk) disable iff (reset)
		!(vol_ctrl.commit && vol_ctrl.cancel));

endmodule

`default_nettype wire

//--- menu_text_lut.sv
`timescale 1ns/1ps
`default_nettype none

module menu_text_lut (
	input wire clk,
	input wire reset,
	input wire phone_ui_pkg::menu_item_t menu_item,
	output phone_ui_pkg::text_req_t text_req
);

	phone_ui_pkg::menu_item_t   prev_item; // item seen last cycle
	logic                       changed;
	logic                       has_text;  // item owns a string
	phone_ui_pkg::text_addr_t   lut_addr;
	phone_ui_pkg::text_addr_t   lut_len;

	assign changed = (menu_item != prev_item);

	//////////////////////////////
	// text table
	//////////////////////////////
	always_comb begin
		has_text = 1'b1;
		lut_addr = '0;
		lut_len  = '0;
		case (menu_item)
			phone_ui_pkg::def_init: begin // press enter to start ...
				lut_addr = 11'd0;
				lut_len  = 11'd45;
			end
			phone_ui_pkg::def_welcome: begin lut_addr = 11'd72;  lut_len = 11'd7;  end
			phone_ui_pkg::call_number: begin lut_addr = 11'd80;  lut_len = 11'd11; end
			phone_ui_pkg::volume:      begin lut_addr = 11'd92;  lut_len = 11'd20; end
			phone_ui_pkg::get_num:     begin lut_addr = 11'd468; lut_len = 11'd21; end
			phone_ui_pkg::set_time:    begin lut_addr = 11'd452; lut_len = 11'd15; end
			// incoming menu
			phone_ui_pkg::def_incoming: begin lut_addr = 11'd361; lut_len = 11'd13; end
			phone_ui_pkg::accept:       begin lut_addr = 11'd375; lut_len = 11'd20; end
			phone_ui_pkg::reject:       begin lut_addr = 11'd396; lut_len = 11'd20; end
			// outgoing menu
			phone_ui_pkg::def_outgoing: begin lut_addr = 11'd435; lut_len = 11'd7; end
			phone_ui_pkg::end_call:     begin lut_addr = 11'd443; lut_len = 11'd8; end
			// busy menu, end call shares its string
			phone_ui_pkg::end_call_b: begin lut_addr = 11'd443; lut_len = 11'd8;  end
			phone_ui_pkg::def_busy:   begin lut_addr = 11'd490; lut_len = 11'd12; end
			default: has_text = 1'b0; // leaf screens and def_sys have no string
		endcase
	end

	//////////////////////////////
	// request register
	//////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			prev_item       <= phone_ui_pkg::def_init; // matches fsm reset, no pulse
			text_req.start  <= 1'b0;
			text_req.addr   <= 11'd0;
			text_req.length <= 11'd45;
		end else begin
			prev_item      <= menu_item;
			text_req.start <= changed && has_text;
			if (changed && has_text) begin
				text_req.addr   <= lut_addr;
				text_req.length <= lut_len;
			end // otherwise hold the last string
		end
	end

	// a change lasts one compare, so the kick is always a single cycle
	a_start_single: assert property (@(posedge clk) disable iff (reset)
		text_req.start |=> !text_req.start);

endmodule

`default_nettype wire

//--- phone_ui_top.sv
`timescale 1ns/1ps
`default_nettype none

module phone_ui_top #(
	parameter phone_ui_pkg::volume_t DEFAULT_VOLUME = 5'd16 // power-up headphone level
) (
	input wire clk,
	input wire reset,
	input wire phone_ui_pkg::buttons_t buttons,
	input wire phone_ui_pkg::phone_num_t dial_switches,
	input wire phone_ui_pkg::app_cmd_t app_command,
	output wire phone_ui_pkg::call_state_t call_state,
	output wire phone_ui_pkg::menu_item_t menu_item,
	output wire phone_ui_pkg::ui_cmd_t ui_command,
	output wire phone_ui_pkg::phone_num_t dial_address,
	output wire phone_ui_pkg::volume_t headphone_volume,
	output wire phone_ui_pkg::text_req_t text_req
);

	wire phone_ui_pkg::vol_ctrl_t vol_ctrl; // fsm -> volume steps

	//////////////////////////////
	// call control
	//////////////////////////////
	call_fsm u_call_fsm (
		.clk           (clk),
		.reset         (reset),
		.buttons       (buttons),
		.dial_switches (dial_switches),
		.app_command   (app_command),
		.call_state    (call_state),
		.menu_item     (menu_item),
		.ui_command    (ui_command),
		.dial_address  (dial_address),
		.vol_ctrl      (vol_ctrl)
	);

	// headphone level
	volume_counter #(
		.DEFAULT_VOLUME (DEFAULT_VOLUME)
	) u_volume_counter (
		.clk              (clk),
		.reset            (reset),
		.vol_ctrl         (vol_ctrl),
		.headphone_volume (headphone_volume)
	);

	// scroller text requests follow the menu
	menu_text_lut u_menu_text_lut (
		.clk       (clk),
		.reset     (reset),
		.menu_item (menu_item),
		.text_req  (text_req)
	);

endmodule

`default_nettype wire

//--- tb_phone_ui.sv
`timescale 1ns/1ps
`default_nettype none

module tb_phone_ui;

	localparam phone_ui_pkg::volume_t DEFAULT_VOLUME = 5'd16;
	localparam int MAX_CYCLES = 2000; // whole run needs a few hundred
	// bit order is enter, up, down, left, right
	localparam phone_ui_pkg::buttons_t BTN_NONE  = 5'b00000;
	localparam phone_ui_pkg::buttons_t BTN_ENTER = 5'b10000;
	localparam phone_ui_pkg::buttons_t BTN_UP    = 5'b01000;
	localparam phone_ui_pkg::buttons_t BTN_DOWN  = 5'b00100;
	localparam phone_ui_pkg::buttons_t BTN_LEFT  = 5'b00010;

	logic                        clk = 1'b0;
	logic                        reset;
	phone_ui_pkg::buttons_t      buttons;
	phone_ui_pkg::phone_num_t    dial_switches;
	phone_ui_pkg::app_cmd_t      app_command;
	phone_ui_pkg::call_state_t   call_state;
	phone_ui_pkg::menu_item_t    menu_item;
	phone_ui_pkg::ui_cmd_t       ui_command;
	phone_ui_pkg::phone_num_t    dial_address;
	phone_ui_pkg::volume_t       headphone_volume;
	phone_ui_pkg::text_req_t     text_req;

	int errors       = 0;
	int tests        = 0;
	int failed_tests = 0;
	int cycle_count  = 0;

	phone_ui_top #(
		.DEFAULT_VOLUME (DEFAULT_VOLUME)
	) dut_i (
		.clk              (clk),
		.reset            (reset),
		.buttons          (buttons),
		.dial_switches    (dial_switches),
		.app_command      (app_command),
		.call_state       (call_state),
		.menu_item        (menu_item),
		.ui_command       (ui_command),
		.dial_address     (dial_address),
		.headphone_volume (headphone_volume),
		.text_req         (text_req)
	);

	always #50 clk = ~clk; // 100 ns period

	// watchdog
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= MAX_CYCLES) begin
			$display("timeout: run stopped after %0d cycles without finishing", cycle_count);
			$display("Test failed");
			$finish;
		end
	end

	//////////////////////////////
	// helpers
	//////////////////////////////
	task automatic check(input string test, input string what, input int exp, input int act);
		if (exp !== act) begin
			$display("ERROR %s: %s expected %0d, actual %0d", test, what, exp, act);
			errors++;
		end
	endtask

	function automatic int clamp_volume(input int v); // 5-bit range
		if (v < 0)
			return 0;
		if (v > 31)
			return 31;
		return v;
	endfunction

	task automatic press(input phone_ui_pkg::buttons_t b);
		@(negedge clk);
		buttons = b; // held one cycle
		@(negedge clk);
		buttons = BTN_NONE;
	endtask

	task automatic report(input phone_ui_pkg::app_cmd_t c);
		@(negedge clk);
		app_command = c;
		@(negedge clk);
		app_command = phone_ui_pkg::app_none;
	endtask

	// waits for the item, then checks the text request one cycle later
	task automatic expect_screen(input string test, input phone_ui_pkg::call_state_t st,
			input phone_ui_pkg::menu_item_t exp, input bit has_text, input int addr,
			input int len);
		int n;
		int old_addr;
		int old_len;
		n        = 0;
		old_addr = int'(text_req.addr); // still the previous string here
		old_len  = int'(text_req.length);
		while (menu_item !== exp && n < 8) begin
			@(negedge clk);
			n++;
		end
		if (menu_item !== exp) begin
			$display("%s: menu never reached %s, still at %s", test, exp.name(),
				menu_item.name());
			errors++;
		end else begin
			check(test, "call state", int'(st), int'(call_state));
			@(negedge clk); // start lags the item by one
			check(test, "text start", int'(has_text), int'(text_req.start));
			check(test, "text addr", has_text ? addr : old_addr, int'(text_req.addr));
			check(test, "text length", has_text ? len : old_len, int'(text_req.length));
			@(negedge clk);
			check(test, "text start after pulse", 0, int'(text_req.start));
		end
	endtask

	task automatic navigate(input string test, input phone_ui_pkg::buttons_t b,
			input phone_ui_pkg::call_state_t st, input phone_ui_pkg::menu_item_t exp,
			input bit has_text, input int addr, input int len);
		press(b);
		expect_screen(test, st, exp, has_text, addr, len);
	endtask

	task automatic finish_test(input string test, input int errors_before);
		tests++;
		if (errors == errors_before) begin
			$display("%s: ok", test);
		end else begin
			failed_tests++;
			$display("%s: %0d errors", test, errors - errors_before);
		end
	endtask

	//////////////////////////////
	// tests
	//////////////////////////////
	task automatic test_reset();
		string t = "reset";
		int    e0;
		e0 = errors;
		check(t, "call state", int'(phone_ui_pkg::initialize), int'(call_state));
		check(t, "menu item", int'(phone_ui_pkg::def_init), int'(menu_item));
		check(t, "ui command", int'(phone_ui_pkg::ui_none), int'(ui_command));
		check(t, "text start", 0, int'(text_req.start));
		check(t, "text addr", 0, int'(text_req.addr));
		check(t, "text length", 45, int'(text_req.length));
		check(t, "volume", int'(DEFAULT_VOLUME), int'(headphone_volume));
		navigate(t, BTN_ENTER, phone_ui_pkg::idle, phone_ui_pkg::def_welcome, 1'b1, 72, 7);
		finish_test(t, e0);
	endtask

	task automatic test_menu();
		string t = "main_menu";
		int    e0;
		e0 = errors;
		navigate(t, BTN_ENTER, phone_ui_pkg::idle, phone_ui_pkg::call_number, 1'b1, 80, 11);
		navigate(t, BTN_DOWN, phone_ui_pkg::idle, phone_ui_pkg::volume, 1'b1, 92, 20);
		navigate(t, BTN_DOWN, phone_ui_pkg::idle, phone_ui_pkg::get_num, 1'b1, 468, 21);
		navigate(t, BTN_DOWN, phone_ui_pkg::idle, phone_ui_pkg::set_time, 1'b1, 452, 15);
		navigate(t, BTN_DOWN, phone_ui_pkg::idle, phone_ui_pkg::call_number, 1'b1, 80, 11);
		navigate(t, BTN_UP, phone_ui_pkg::idle, phone_ui_pkg::set_time, 1'b1, 452, 15);
		navigate(t, BTN_LEFT, phone_ui_pkg::idle, phone_ui_pkg::def_sys, 1'b0, 0, 0);
		finish_test(t, e0);
	endtask

	task automatic test_volume();
		string t = "volume";
		int    e0;
		int    exp_vol;
		e0 = errors;
		navigate(t, BTN_ENTER, phone_ui_pkg::idle, phone_ui_pkg::call_number, 1'b1, 80, 11);
		navigate(t, BTN_DOWN, phone_ui_pkg::idle, phone_ui_pkg::volume, 1'b1, 92, 20);
		navigate(t, BTN_ENTER, phone_ui_pkg::idle, phone_ui_pkg::change_vol, 1'b0, 0, 0);
		repeat (20)
			press(BTN_UP);
		exp_vol = clamp_volume(int'(DEFAULT_VOLUME) + 20); // saturates
		check(t, "volume before commit", int'(DEFAULT_VOLUME), int'(headphone_volume));
		navigate(t, BTN_ENTER, phone_ui_pkg::idle, phone_ui_pkg::volume, 1'b1, 92, 20);
		check(t, "volume after commit", exp_vol, int'(headphone_volume));
		// steps then cancel leave the level where it was
		navigate(t, BTN_ENTER, phone_ui_pkg::idle, phone_ui_pkg::change_vol, 1'b0, 0, 0);
		repeat (3)
			press(BTN_DOWN);
		navigate(t, BTN_LEFT, phone_ui_pkg::idle, phone_ui_pkg::volume, 1'b1, 92, 20);
		check(t, "volume after cancel", exp_vol, int'(headphone_volume));
		// bare commit shows the pending level was reloaded
		navigate(t, BTN_ENTER, phone_ui_pkg::idle, phone_ui_pkg::change_vol, 1'b0, 0, 0);
		navigate(t, BTN_ENTER, phone_ui_pkg::idle, phone_ui_pkg::volume, 1'b1, 92, 20);
		check(t, "volume after cancel and commit", exp_vol, int'(headphone_volume));
		navigate(t, BTN_ENTER, phone_ui_pkg::idle, phone_ui_pkg::change_vol, 1'b0, 0, 0);
		repeat (40)
			press(BTN_DOWN);
		exp_vol = clamp_volume(exp_vol - 40); // floor at zero
		navigate(t, BTN_ENTER, phone_ui_pkg::idle, phone_ui_pkg::volume, 1'b1, 92, 20);
		check(t, "volume after second commit", exp_vol, int'(headphone_volume));
		finish_test(t, e0);
	endtask

	task automatic test_outgoing();
		string                    t = "outgoing";
		int                       e0;
		phone_ui_pkg::phone_num_t number;
		e0 = errors;
		navigate(t, BTN_UP, phone_ui_pkg::idle, phone_ui_pkg::call_number, 1'b1, 80, 11);
		navigate(t, BTN_ENTER, phone_ui_pkg::idle, phone_ui_pkg::dialing, 1'b0, 0, 0);
		@(negedge clk);
		number        = phone_ui_pkg::phone_num_t'($urandom);
		dial_switches = number;
		navigate(t, BTN_ENTER, phone_ui_pkg::outgoing, phone_ui_pkg::def_outgoing, 1'b1, 435, 7);
		check(t, "ui command", int'(phone_ui_pkg::make_call), int'(ui_command));
		check(t, "dial address", int'(number), int'(dial_address));
		report(phone_ui_pkg::connected);
		expect_screen(t, phone_ui_pkg::busy, phone_ui_pkg::def_busy, 1'b1, 490, 12);
		navigate(t, BTN_DOWN, phone_ui_pkg::busy, phone_ui_pkg::end_call_b, 1'b1, 443, 8);
		press(BTN_ENTER);
		@(negedge clk); // command one edge after the sample
		check(t, "ui command", int'(phone_ui_pkg::stop_call), int'(ui_command));
		report(phone_ui_pkg::call_ended);
		expect_screen(t, phone_ui_pkg::idle, phone_ui_pkg::def_sys, 1'b0, 0, 0);
		check(t, "ui command", int'(phone_ui_pkg::ui_none), int'(ui_command));
		finish_test(t, e0);
	endtask

	task automatic test_incoming();
		string t = "incoming";
		int    e0;
		e0 = errors;
		report(phone_ui_pkg::incoming_call);
		expect_screen(t, phone_ui_pkg::incoming, phone_ui_pkg::def_incoming, 1'b1, 361, 13);
		navigate(t, BTN_DOWN, phone_ui_pkg::incoming, phone_ui_pkg::accept, 1'b1, 375, 20);
		navigate(t, BTN_ENTER, phone_ui_pkg::busy, phone_ui_pkg::def_busy, 1'b1, 490, 12);
		report(phone_ui_pkg::call_ended);
		expect_screen(t, phone_ui_pkg::idle, phone_ui_pkg::def_sys, 1'b0, 0, 0);
		// second call gets turned away
		report(phone_ui_pkg::incoming_call);
		expect_screen(t, phone_ui_pkg::incoming, phone_ui_pkg::def_incoming, 1'b1, 361, 13);
		navigate(t, BTN_DOWN, phone_ui_pkg::incoming, phone_ui_pkg::accept, 1'b1, 375, 20);
		navigate(t, BTN_DOWN, phone_ui_pkg::incoming, phone_ui_pkg::reject, 1'b1, 396, 20);
		navigate(t, BTN_ENTER, phone_ui_pkg::idle, phone_ui_pkg::def_sys, 1'b0, 0, 0);
		check(t, "ui command", int'(phone_ui_pkg::ui_none), int'(ui_command));
		finish_test(t, e0);
	endtask

	task automatic test_failed();
		string t = "failed_call";
		int    e0;
		e0 = errors;
		navigate(t, BTN_ENTER, phone_ui_pkg::idle, phone_ui_pkg::call_number, 1'b1, 80, 11);
		navigate(t, BTN_ENTER, phone_ui_pkg::idle, phone_ui_pkg::dialing, 1'b0, 0, 0);
		navigate(t, BTN_ENTER, phone_ui_pkg::outgoing, phone_ui_pkg::def_outgoing, 1'b1, 435, 7);
		check(t, "ui command", int'(phone_ui_pkg::make_call), int'(ui_command));
		report(phone_ui_pkg::failed);
		expect_screen(t, phone_ui_pkg::idle, phone_ui_pkg::def_sys, 1'b0, 0, 0);
		check(t, "ui command", int'(phone_ui_pkg::ui_none), int'(ui_command));
		finish_test(t, e0);
	endtask

	//////////////////////////////
	// main sequence
	//////////////////////////////
	initial begin
		void'($urandom(32'ha953ecb5)); // only the dialed number is random
		reset         = 1'b1;
		buttons       = BTN_NONE;
		dial_switches = '0;
		app_command   = phone_ui_pkg::app_none;
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		test_reset();
		test_menu();
		test_volume();
		test_outgoing();
		test_incoming();
		test_failed();
		$display("%0d tests, %0d failing, %0d errors", tests, failed_tests, errors);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- tb.f
phone_ui_pkg.sv
call_fsm.sv
volume_counter.sv
menu_text_lut.sv
phone_ui_top.sv
tb_phone_ui.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_phone_ui
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "Test passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
